// File: Makefile
TOP := csa_stream_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f csa_stream.f

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) \
		-f csa_stream.f --Mdir obj_dir -o csa_stream_sim
	./obj_dir/csa_stream_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// File: csa_stream.f
hw/csa_pkg.sv
hw/csa_unpack.sv
hw/csa_tree.sv
hw/csa_pack.sv
hw/csa_stream_top.sv
tb/csa_stream_props.sv
tb/csa_stream_tb.sv

// File: hw/csa_pack.sv
`timescale 1ns/10ps

module csa_pack (
	input  logic           clk,
	input  logic           reset,
	input  logic           sum_valid,
	input  csa_pkg::sum_t  sum_data,
	input  logic           frame_error,
	output logic           out_valid,
	output csa_pkg::word_t out_data,
	output logic           out_last
);

	localparam int PAIR_W = csa_pkg::GROUPS_PER_PAIR * csa_pkg::SUM_W;
	localparam int CNT_W  = $clog2(csa_pkg::WORDS_PER_PAIR);
	localparam int ALIGN  = 2; // Cycles through the tree.

	localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(csa_pkg::WORDS_PER_PAIR - 1);

	csa_pkg::pack_state_t state;

	logic [PAIR_W-1:0] pair;
	logic [CNT_W-1:0]  word_cnt;
	logic [ALIGN-1:0]  err_pipe;
	logic              err_aligned;

	// A group of the dropped frame may still be in the tree when the error arrives.
	assign err_aligned = err_pipe[ALIGN-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= csa_pkg::PACK_IDLE;
			word_cnt <= '0;
			err_pipe <= '0;
		end else begin
			err_pipe <= {err_pipe[ALIGN-2:0], frame_error};

			case (state)
				csa_pkg::PACK_IDLE: begin
					if (sum_valid && !err_aligned) begin
						state <= csa_pkg::PACK_HALF;
					end
				end
				csa_pkg::PACK_HALF: begin
					if (err_aligned) begin
						state <= csa_pkg::PACK_IDLE; // Forget the half pair.
					end else if (sum_valid) begin
						state    <= csa_pkg::PACK_EMIT;
						word_cnt <= '0;
					end
				end
				csa_pkg::PACK_EMIT: begin
					if (word_cnt == LAST_WORD) begin
						state <= csa_pkg::PACK_IDLE;
					end else begin
						word_cnt <= word_cnt + 1'b1;
					end
				end
				default: begin
					state <= csa_pkg::PACK_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (sum_valid && state == csa_pkg::PACK_IDLE) begin
			pair[0 +: csa_pkg::SUM_W] <= sum_data;
		end
		if (sum_valid && state == csa_pkg::PACK_HALF) begin
			pair[csa_pkg::SUM_W +: csa_pkg::SUM_W] <= sum_data;
		end
	end

	assign out_valid = state == csa_pkg::PACK_EMIT;
	assign out_last  = out_valid && word_cnt == LAST_WORD;
	assign out_data  = pair[word_cnt*csa_pkg::WORD_W +: csa_pkg::WORD_W];

endmodule

// File: hw/csa_pkg.sv
package csa_pkg;

	localparam int WORD_W          = 32;
	localparam int OPERAND_W       = 40;
	localparam int SUM_W           = 48;

	localparam int WORDS_PER_GROUP = 5;
	localparam int OPS_PER_GROUP   = 4;
	localparam int GROUPS_PER_PAIR = 2;
	localparam int WORDS_PER_PAIR  = 3;

	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [OPERAND_W-1:0] operand_t;
	typedef logic [SUM_W-1:0]     sum_t;

	// Operand 0 sits in the low bits.
	typedef logic [OPS_PER_GROUP*OPERAND_W-1:0] group_t;

	typedef enum logic [1:0] {
		PACK_IDLE,
		PACK_HALF,
		PACK_EMIT
	} pack_state_t;

endpackage

// File: hw/csa_stream_top.sv
`timescale 1ns/10ps

module csa_stream_top (
	input  logic           clk,
	input  logic           reset,
	input  logic           in_valid,
	input  csa_pkg::word_t in_data,
	input  logic           in_last,
	output logic           out_valid,
	output csa_pkg::word_t out_data,
	output logic           out_last,
	output logic           frame_error
);

	logic            grp_valid;
	csa_pkg::group_t grp_data;

	logic            sum_valid;
	csa_pkg::sum_t   sum_data;

	// Decode.
	csa_unpack u_unpack (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_last     (in_last),
		.grp_valid   (grp_valid),
		.grp_data    (grp_data),
		.frame_error (frame_error)
	);

	// Execute.
	csa_tree u_tree (
		.clk       (clk),
		.reset     (reset),
		.grp_valid (grp_valid),
		.grp_data  (grp_data),
		.sum_valid (sum_valid),
		.sum_data  (sum_data)
	);

	// Result.
	csa_pack u_pack (
		.clk         (clk),
		.reset       (reset),
		.sum_valid   (sum_valid),
		.sum_data    (sum_data),
		.frame_error (frame_error),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.out_last    (out_last)
	);

endmodule

// File: hw/csa_tree.sv
`timescale 1ns/10ps

module csa_tree (
	input  logic            clk,
	input  logic            reset,
	input  logic            grp_valid,
	input  csa_pkg::group_t grp_data,
	output logic            sum_valid,
	output csa_pkg::sum_t   sum_data
);

	localparam int PAD_W = csa_pkg::SUM_W - csa_pkg::OPERAND_W;

	function automatic csa_pkg::sum_t widen(input csa_pkg::operand_t x);
		return {{PAD_W{1'b0}}, x};
	endfunction

	// 3:2 compressor, carry already shifted into place.
	function automatic logic [2*csa_pkg::SUM_W-1:0] compress(
		input csa_pkg::sum_t x,
		input csa_pkg::sum_t y,
		input csa_pkg::sum_t z
	);
		csa_pkg::sum_t s;
		csa_pkg::sum_t c;
		s = x ^ y ^ z;
		c = ((x & y) | (x & z) | (y & z)) << 1;
		return {c, s};
	endfunction

	csa_pkg::operand_t operand [csa_pkg::OPS_PER_GROUP];
	csa_pkg::sum_t     op_wide [csa_pkg::OPS_PER_GROUP];

	csa_pkg::sum_t l1_sum;
	csa_pkg::sum_t l1_carry;
	csa_pkg::sum_t l2_sum;
	csa_pkg::sum_t l2_carry;

	csa_pkg::sum_t save_sum;
	csa_pkg::sum_t save_carry;
	logic          stage1_valid;

	always_comb begin
		for (int j = 0; j < csa_pkg::OPS_PER_GROUP; j++) begin
			operand[j] = grp_data[j*csa_pkg::OPERAND_W +: csa_pkg::OPERAND_W];
			op_wide[j] = widen(operand[j]);
		end
	end

	// Four operands down to two in two levels.
	assign {l1_carry, l1_sum} = compress(op_wide[0], op_wide[1], op_wide[2]);
	assign {l2_carry, l2_sum} = compress(l1_sum, l1_carry, op_wide[3]);

	always_ff @(posedge clk) begin
		if (grp_valid) begin
			save_sum   <= l2_sum;
			save_carry <= l2_carry;
		end
	end

	// Single carry-propagate add.
	always_ff @(posedge clk) begin
		if (stage1_valid) begin
			sum_data <= save_sum + save_carry;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stage1_valid <= 1'b0;
			sum_valid    <= 1'b0;
		end else begin
			stage1_valid <= grp_valid;
			sum_valid    <= stage1_valid;
		end
	end

endmodule

// File: hw/csa_unpack.sv
`timescale 1ns/10ps

module csa_unpack (
	input  logic            clk,
	input  logic            reset,
	input  logic            in_valid,
	input  csa_pkg::word_t  in_data,
	input  logic            in_last,
	output logic            grp_valid,
	output csa_pkg::group_t grp_data,
	output logic            frame_error
);

	localparam int WCNT_W = $clog2(csa_pkg::WORDS_PER_GROUP);
	localparam int GCNT_W = $clog2(csa_pkg::GROUPS_PER_PAIR);
	localparam int GROUP_W = $bits(csa_pkg::group_t);

	localparam logic [WCNT_W-1:0] LAST_WORD  = WCNT_W'(csa_pkg::WORDS_PER_GROUP - 1);
	localparam logic [GCNT_W-1:0] LAST_GROUP = GCNT_W'(csa_pkg::GROUPS_PER_PAIR - 1);

	logic [WCNT_W-1:0] word_cnt;
	logic [GCNT_W-1:0] grp_cnt;
	csa_pkg::group_t   gather;
	csa_pkg::group_t   gather_next;

	logic group_done;
	logic pair_done;
	logic bad_last;

	// Newest word enters at the top, so word 0 ends in the low bits.
	assign gather_next = {in_data, gather[GROUP_W-1:csa_pkg::WORD_W]};

	assign group_done = word_cnt == LAST_WORD;
	assign pair_done  = grp_cnt == LAST_GROUP;

	// Only the tenth word of a pair may close a frame.
	assign bad_last = in_valid && in_last && !(group_done && pair_done);

	always_ff @(posedge clk) begin
		if (in_valid) begin
			gather <= gather_next;
		end
	end

	// Gather stays put for the grp_valid cycle.
	assign grp_data = gather;

	always_ff @(posedge clk) begin
		if (reset) begin
			word_cnt    <= '0;
			grp_cnt     <= '0;
			grp_valid   <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			grp_valid   <= in_valid && group_done;
			frame_error <= bad_last;

			if (bad_last) begin
				word_cnt <= '0; // Drop the partial frame.
				grp_cnt  <= '0;
			end else if (in_valid) begin
				if (group_done) begin
					word_cnt <= '0;
					if (pair_done) begin
						grp_cnt <= '0;
					end else begin
						grp_cnt <= grp_cnt + 1'b1;
					end
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: tb/csa_stream_props.sv
`timescale 1ns/10ps

module csa_stream_props (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input logic out_last,
	input logic frame_error
);

	// The third word of a pair closes the burst.
	last_ends_burst: assert property (@(posedge clk) disable iff (reset)
		out_last |-> out_valid && $past(out_valid) && $past(out_valid, 2))
		else $error("out_last not on the third word of an out_valid burst");

	// A pair is three words long.
	burst_max_three: assert property (@(posedge clk) disable iff (reset)
		!(out_valid && $past(out_valid) && $past(out_valid, 2) && $past(out_valid, 3)))
		else $error("out_valid high for more than three cycles in a row");

	quiet_in_reset: assert property (@(posedge clk)
		reset |=> !out_valid && !out_last && !frame_error)
		else $error("outputs not low after a reset cycle");

	error_not_in_burst: assert property (@(posedge clk) disable iff (reset)
		frame_error |-> !out_valid)
		else $error("frame_error high together with out_valid");

endmodule

bind csa_stream_top csa_stream_props u_props (
	.clk         (clk),
	.reset       (reset),
	.out_valid   (out_valid),
	.out_last    (out_last),
	.frame_error (frame_error)
);

// File: tb/csa_stream_tb.sv
`timescale 1ns/10ps

module csa_stream_tb;

	localparam int SEED            = 22;
	localparam int RESET_CYCLES    = 10;
	localparam int DRAIN_CYCLES    = 16;
	localparam int RAND_FRAMES     = 20;
	localparam int LAT_FRAMES      = 5;
	localparam int PIPE_LATENCY    = 4;
	localparam int TOTAL_WORDS     = 4*10 + 2*RAND_FRAMES*10 + LAT_FRAMES*10 + 25 + 16;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS*20 + 200;

	localparam logic [39:0] ONES  = {40{1'b1}};
	localparam logic [39:0] BIT39 = 40'h80_0000_0000;

	logic        clk = 1'b0;
	logic        reset;
	logic        in_valid;
	logic [31:0] in_data;
	logic        in_last;
	logic        out_valid;
	logic [31:0] out_data;
	logic        out_last;
	logic        frame_error;

	logic [31:0]  exp_q [$];
	logic [31:0]  stamp_q [$];
	logic [31:0]  got_q [$];
	logic [31:0]  test2_q [$];
	logic [319:0] saved [RAND_FRAMES];

	logic [31:0] cyc = '0;
	int          errors = 0;
	int          pulses = 0;
	int          pulse_base;
	int          err_base;
	int          tests_run = 0;
	int          tests_failed = 0;

	int          cmp_pos = 0;
	logic [31:0] cmp_exp;
	logic [31:0] cmp_stamp;

	csa_stream_top u_dut (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_last     (in_last),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.out_last    (out_last),
		.frame_error (frame_error)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// Outputs change on the rising edge, so look at them on the falling one.
	always @(negedge clk) begin
		if (!reset && frame_error) begin
			pulses++;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// Expected pair of sums, words at 32k and operands at 40j.
	function automatic logic [95:0] csa_ref(input logic [319:0] words);
		logic [159:0] grp;
		logic [47:0]  total;
		logic [95:0]  pair;
		pair = '0;
		for (int g = 0; g < 2; g++) begin
			grp   = words[160*g +: 160];
			total = '0;
			for (int j = 0; j < 4; j++) begin
				total = total + {8'h00, grp[40*j +: 40]};
			end
			pair[48*g +: 48] = total;
		end
		return pair;
	endfunction

	always @(negedge clk) begin
		if (reset) begin
			cmp_pos = 0;
		end else if (out_valid) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected output word 0x%h with no result pending", out_data);
				errors++;
			end else begin
				cmp_exp = exp_q.pop_front();
				check_val("out_data", out_data, cmp_exp);
				check_val("out_last", 32'(out_last), 32'(cmp_pos == 2));
				if (cmp_pos == 0) begin
					cmp_stamp = stamp_q.pop_front();
					check_val("out_valid latency", cyc - cmp_stamp, 32'(PIPE_LATENCY));
				end
				got_q.push_back(out_data);
				cmp_pos = (cmp_pos == 2) ? 0 : cmp_pos + 1;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	function automatic logic [159:0] group_of(input logic [39:0] a, b, c, d);
		return {d, c, b, a};
	endfunction

	function automatic logic [319:0] random_frame();
		logic [319:0] f;
		for (int k = 0; k < 10; k++) begin
			f[32*k +: 32] = $urandom();
		end
		return f;
	endfunction

	task automatic drive_word(input logic [31:0] data, input logic last);
		@(negedge clk);
		in_valid = 1'b1;
		in_data  = data;
		in_last  = last;
	endtask

	task automatic go_idle();
		@(negedge clk);
		in_valid = 1'b0;
		in_last  = 1'b0;
	endtask

	task automatic hold_reset();
		reset    = 1'b1;
		in_valid = 1'b0;
		in_last  = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic send_frame(input logic [319:0] frame, input int max_gap);
		logic [95:0] pair;
		int          gap;
		pair = csa_ref(frame);
		for (int m = 0; m < 3; m++) begin
			exp_q.push_back(pair[32*m +: 32]);
		end
		for (int k = 0; k < 10; k++) begin
			gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
			repeat (gap) go_idle();
			drive_word(frame[32*k +: 32], k == 9);
		end
		stamp_q.push_back(cyc); // Cycle of the tenth word.
	endtask

	task automatic send_bad(input int len);
		for (int k = 0; k < len; k++) begin
			drive_word($urandom(), k == len - 1);
		end
		go_idle();
		repeat (4) @(negedge clk);
	endtask

	task automatic start_test();
		err_base   = errors;
		pulse_base = pulses;
		got_q.delete();
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (DRAIN_CYCLES) @(negedge clk); // Catch stray words.
	endtask

	task automatic end_test(input string name, input int exp_pulses);
		wait_drain();
		check_val("frame_error pulses", 32'(pulses - pulse_base), 32'(exp_pulses));
		tests_run++;
		if (errors == err_base) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors - err_base);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		in_data = '0;
		hold_reset();

		// Carries run into bits 40 and 41.
		start_test();
		send_frame({group_of(40'h0, 40'h0, 40'h0, 40'h0), group_of(40'h0, 40'h0, 40'h0, 40'h0)}, 0);
		send_frame({group_of(ONES, ONES, ONES, ONES), group_of(ONES, ONES, ONES, ONES)}, 0);
		send_frame({group_of(40'h1, 40'h2000, 40'h800_0000, BIT39),
			group_of(BIT39, BIT39, BIT39, BIT39)}, 0);
		send_frame({group_of(ONES, BIT39, ONES, BIT39), group_of(ONES, ONES, ONES, 40'h1)}, 0);
		go_idle();
		end_test("1 directed sums", 0);

		start_test();
		for (int i = 0; i < RAND_FRAMES; i++) begin
			saved[i] = random_frame();
			send_frame(saved[i], 0);
		end
		go_idle();
		end_test("2 back-to-back stream", 0);
		test2_q = got_q;

		start_test();
		for (int i = 0; i < RAND_FRAMES; i++) begin
			send_frame(saved[i], 3);
		end
		go_idle();
		wait_drain();
		check_val("output word count", 32'(got_q.size()), 32'(test2_q.size()));
		for (int i = 0; i < got_q.size() && i < test2_q.size(); i++) begin
			check_val("out_data against test 2", got_q[i], test2_q[i]);
		end
		end_test("3 gapped input", 0);

		// Latency is checked on every pair by the compare process.
		start_test();
		for (int i = 0; i < LAT_FRAMES; i++) begin
			send_frame(random_frame(), 1);
			go_idle();
			repeat (i + 1) @(negedge clk);
		end
		end_test("4 exact latency", 0);

		start_test();
		send_bad(3);
		send_bad(5);
		send_bad(7);
		send_frame(random_frame(), 0);
		go_idle();
		end_test("5 misplaced in_last", 3);

		start_test();
		for (int k = 0; k < 6; k++) begin
			drive_word($urandom(), 1'b0);
		end
		@(negedge clk);
		hold_reset();
		send_frame(random_frame(), 0);
		go_idle();
		end_test("6 reset mid-frame", 0);

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
